//--- sst_pkg.sv
`default_nettype none

package sst_pkg;

    ////////////////////////////////
    // Memory port sizes.
    ////////////////////////////////
    localparam int WORD_W    = 16;              // Data word.
    localparam int ADDR_W    = 24;              // Bank + row + column.
    localparam int BURST_LEN = 4;               // Words per burst.
    localparam int WIDX_W    = $clog2(BURST_LEN);
    localparam int FRAME_W   = 11;              // Start, 8 data, 2 stop.

    // Byte view of one word.
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_t;

    // One memory word, flat or split into bytes.
    typedef union packed {
        logic [WORD_W-1:0] word;
        byte_pair_t        bytes;
    } mem_word_u;

    typedef mem_word_u [BURST_LEN-1:0] burst_t;  // Word 0 at index 0.

    // Request towards the burst memory.
    typedef struct packed {
        logic              wr;    // Held until wr_done.
        logic              rd;    // Held until rd_done.
        logic [ADDR_W-1:0] addr;
        burst_t            data;
    } mem_req_t;

    // Answer from the burst memory.
    typedef struct packed {
        logic   wr_done;          // One cycle.
        logic   rd_done;          // One cycle, data valid.
        burst_t data;
    } mem_rsp_t;

    // Which byte of the read burst goes out next.
    typedef struct packed {
        logic [WIDX_W-1:0] word;
        logic              lo;    // 0 = high byte first.
    } byte_sel_t;

    typedef enum logic {
        TM_BIT,                   // One UART bit period.
        TM_PAUSE                  // Gap between passes.
    } timer_mode_e;

endpackage

`default_nettype wire

//--- step_timer.sv
`default_nettype none

module step_timer import sst_pkg::*; #(
    parameter int BAUD_DIV     = 1157,
    parameter int PAUSE_CYCLES = 2222222
) (
    input  wire         clk_133MHz_210,
    input  wire         rst_n,
    input  wire         start,
    input  timer_mode_e mode,
    output logic        expired
);

    localparam int MAX_LOAD = (PAUSE_CYCLES > BAUD_DIV) ? PAUSE_CYCLES : BAUD_DIV;
    localparam int CNT_W    = $clog2(MAX_LOAD + 1);

    logic [CNT_W-1:0] cnt;      // Cycles left minus one.
    logic             busy;

    assign expired = busy && (cnt == '0);   // Last cycle of the period.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            busy <= 1'b0;
        end else if (start) begin
            cnt  <= (mode == TM_PAUSE) ? CNT_W'(PAUSE_CYCLES - 1) : CNT_W'(BAUD_DIV - 1);
            busy <= 1'b1;
        end else if (busy) begin
            if (cnt == '0) busy <= 1'b0;    // Run out.
            else           cnt  <= cnt - 1'b1;
        end
    end

    // Restart only as the running period ends.
    a_no_overlap: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        start |-> (!busy || expired));

endmodule

`default_nettype wire

//--- pattern_checker.sv
`default_nettype none

module pattern_checker import sst_pkg::*; (
    input  wire        clk_133MHz_210,
    input  wire        rst_n,
    input  wire        capture,
    input  wire        advance,
    input  wire burst_t rd_data,
    input  wire byte_sel_t byte_sel,
    output burst_t     wr_data,
    output logic       word_match,
    output logic [7:0] tx_byte
);

    logic [WORD_W-1:0] pattern;     // Pass number.
    burst_t            rd_buf;      // Burst read back.
    mem_word_u         sel_word;

    //////////////////////////////
    // Write pattern.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            pattern <= '0;
        end else if (advance) begin
            pattern <= pattern + 1'b1;  // Wraps after 64K passes.
        end
    end

    always_comb begin
        for (int i = 0; i < BURST_LEN; i++) begin
            wr_data[i].word = pattern;  // Same value in every word.
        end
    end

    // Read capture on rd_done.
    always_ff @(posedge clk_133MHz_210) begin
        if (capture) rd_buf <= rd_data;
    end

    //////////////////////////////
    // Compare and byte pick.
    //////////////////////////////
    assign sel_word   = rd_buf[byte_sel.word];
    assign word_match = (sel_word.word == pattern);
    assign tx_byte    = byte_sel.lo ? sel_word.bytes.lo : sel_word.bytes.hi;

endmodule

`default_nettype wire

//--- uart_frame_shifter.sv
`default_nettype none

module uart_frame_shifter import sst_pkg::*; (
    input  wire        clk_133MHz_210,
    input  wire        rst_n,
    input  wire        frame_load,
    input  wire [7:0]  tx_byte,
    input  wire        bit_step,
    output logic       uart_txd
);

    // Bit 0 is on the line, ones fill in from the top.
    logic [FRAME_W-1:0] frame_sr;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame_sr <= '1;                                 // Line idles high.
        end else if (frame_load) begin
            frame_sr <= {{(FRAME_W - 9){1'b1}}, tx_byte, 1'b0};  // Stops, data, start.
        end else if (bit_step) begin
            frame_sr <= {1'b1, frame_sr[FRAME_W-1:1]};      // LSB first.
        end
    end

    assign uart_txd = frame_sr[0];

    // New frame only once the previous one has fully left.
    a_load_idle: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        frame_load |-> (&frame_sr[FRAME_W-1:1]));

endmodule

`default_nettype wire

//--- test_sequencer.sv
`default_nettype none

module test_sequencer import sst_pkg::*; #(
    parameter int FRAME_WORDS = 384000      // Multiple of BURST_LEN.
) (
    input  wire               clk_133MHz_210,
    input  wire               rst_n,
    input  wire               wr_done,
    input  wire               rd_done,
    input  wire               word_match,
    input  wire               timer_expired,
    output logic              wr,
    output logic              rd,
    output logic [ADDR_W-1:0] addr,
    output logic              capture,
    output logic              advance,
    output byte_sel_t         byte_sel,
    output logic              frame_load,
    output logic              bit_step,
    output logic              timer_start,
    output timer_mode_e       timer_mode,
    output logic              led
);

    localparam int BYTES  = 2 * BURST_LEN;          // Bytes sent per pass.
    localparam int BCNT_W = $clog2(BYTES + 1);
    localparam int BIT_W  = $clog2(FRAME_W);

    typedef enum logic [2:0] {
        S_WRITE, S_READ, S_CHECK, S_SEND, S_PAUSE, S_NEXT, S_HALT_ERR, S_HALT_DONE
    } state_e;

    state_e            state;
    logic [BCNT_W-1:0] byte_cnt;    // Frames loaded this pass.
    logic [BIT_W-1:0]  bit_cnt;     // Bit on the line now.
    logic              last_bit;
    logic              frame_end;
    logic              pass_sent;
    logic              want_frame;  // A new frame is due.
    logic              pause_go;
    logic              last_burst;

    //////////////////////////////
    // Step decode.
    //////////////////////////////
    assign last_bit   = (bit_cnt == BIT_W'(FRAME_W - 1));
    assign bit_step   = (state == S_SEND) && timer_expired;
    assign frame_end  = bit_step && last_bit;             // Second stop bit done.
    assign pass_sent  = (byte_cnt == BCNT_W'(BYTES));
    assign want_frame = (state == S_CHECK) || (frame_end && !pass_sent);
    assign frame_load = want_frame && word_match;         // Back to back frames.
    assign pause_go   = frame_end && pass_sent;
    assign timer_start = frame_load || (bit_step && !last_bit) || pause_go;
    assign timer_mode  = pause_go ? TM_PAUSE : TM_BIT;

    assign capture    = (state == S_READ) && rd_done;
    assign last_burst = (32'(addr) + 32'(BURST_LEN)) >= 32'(FRAME_WORDS);
    assign advance    = (state == S_NEXT) && !last_burst;

    // Word 0 high byte goes first, then its low byte, then word 1.
    assign byte_sel = '{word: byte_cnt[WIDX_W:1], lo: byte_cnt[0]};

    //////////////////////////////
    // Pass FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_WRITE;
            addr     <= '0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            wr       <= 1'b0;
            rd       <= 1'b0;
            led      <= 1'b0;
        end else begin
            case (state)
                S_WRITE: begin
                    if (wr_done) begin          // Drop request after done.
                        wr    <= 1'b0;
                        state <= S_READ;
                    end else begin
                        wr <= 1'b1;
                    end
                end
                S_READ: begin
                    if (rd_done) begin
                        rd    <= 1'b0;
                        state <= S_CHECK;
                    end else begin
                        rd <= 1'b1;
                    end
                end
                S_CHECK, S_SEND: begin
                    if (frame_load) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        bit_cnt  <= '0;
                        state    <= S_SEND;
                    end else if (want_frame) begin  // Mismatch sends nothing.
                        led   <= 1'b1;
                        state <= S_HALT_ERR;
                    end else if (pause_go) begin
                        state <= S_PAUSE;
                    end else if (bit_step) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_PAUSE: begin
                    if (timer_expired) state <= S_NEXT;
                end
                S_NEXT: begin
                    byte_cnt <= '0;
                    if (last_burst) begin
                        state <= S_HALT_DONE;   // Frame buffer covered.
                    end else begin
                        addr  <= addr + ADDR_W'(BURST_LEN);
                        state <= S_WRITE;
                    end
                end
                default: state <= state;        // Both halts hold.
            endcase
        end
    end

    // Memory sees one command at a time.
    a_one_cmd: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !(wr && rd));

    // Error indication is sticky.
    a_led_sticky: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        led |=> led);

endmodule

`default_nettype wire

//--- sdram_self_test.sv
`default_nettype none

module sdram_self_test import sst_pkg::*; #(
    parameter int BAUD_DIV     = 1157,      // 133.33 MHz / 115200.
    parameter int PAUSE_CYCLES = 2222222,   // Gap between passes.
    parameter int FRAME_WORDS  = 384000     // 480 x 800 frame buffer.
) (
    input  wire      clk_133MHz_210,
    input  wire      rst_n,
    output mem_req_t mem_req,
    input  wire mem_rsp_t mem_rsp,
    output logic     uart_txd,
    output logic     led
);

    ////////////////////////////////
    // Internal wiring.
    ////////////////////////////////
    logic        timer_start;
    timer_mode_e timer_mode;
    logic        timer_expired;
    logic        capture;               // Latch read burst.
    logic        advance;               // Next pattern.
    byte_sel_t   byte_sel;
    logic        word_match;
    logic [7:0]  tx_byte;
    logic        frame_load;
    logic        bit_step;

    // Pass control.
    test_sequencer #(
        .FRAME_WORDS (FRAME_WORDS)
    ) i_sequencer (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .wr_done        (mem_rsp.wr_done),
        .rd_done        (mem_rsp.rd_done),
        .word_match     (word_match),
        .timer_expired  (timer_expired),
        .wr             (mem_req.wr),
        .rd             (mem_req.rd),
        .addr           (mem_req.addr),
        .capture        (capture),
        .advance        (advance),
        .byte_sel       (byte_sel),
        .frame_load     (frame_load),
        .bit_step       (bit_step),
        .timer_start    (timer_start),
        .timer_mode     (timer_mode),
        .led            (led)
    );

    // Bit and pause timing.
    step_timer #(
        .BAUD_DIV     (BAUD_DIV),
        .PAUSE_CYCLES (PAUSE_CYCLES)
    ) i_timer (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .start          (timer_start),
        .mode           (timer_mode),
        .expired        (timer_expired)
    );

    pattern_checker i_checker (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .capture        (capture),
        .advance        (advance),
        .rd_data        (mem_rsp.data),
        .byte_sel       (byte_sel),
        .wr_data        (mem_req.data),
        .word_match     (word_match),
        .tx_byte        (tx_byte)
    );

    uart_frame_shifter i_shifter (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .frame_load     (frame_load),
        .tx_byte        (tx_byte),
        .bit_step       (bit_step),
        .uart_txd       (uart_txd)
    );

endmodule

`default_nettype wire

//--- tb_burst_memory.sv
`default_nettype none

module tb_burst_memory import sst_pkg::*; #(
    parameter logic [31:0] SEED = 32'h626ecd77
) (
    input  wire                    clk_133MHz_210,
    input  wire                    rst_n,
    input  wire mem_req_t          mem_req,
    output mem_rsp_t               mem_rsp,
    input  wire                    fault_en,     // Corrupt one read.
    input  wire [7:0]              fault_read,   // Read index since reset.
    input  wire [WIDX_W-1:0]       fault_word,
    input  wire [3:0]              fault_bit
);

    timeunit 1ns;
    timeprecision 100ps;

    mem_word_u   store [int unsigned];  // Sparse word storage.
    logic [31:0] rng;
    int          lat;
    burst_t      rd_burst;
    int unsigned key;
    logic [7:0]  rd_count;              // Reads answered since reset.

    // Xorshift32 step.
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    //////////////////////////////
    // Request service loop.
    //////////////////////////////
    initial begin
        rng      = SEED;
        mem_rsp  = '0;
        rd_count = 8'd0;
        forever begin
            @(posedge clk_133MHz_210);
            #1;                                 // DUT outputs settled.
            if (!rst_n) begin
                rd_count = 8'd0;
            end else if (mem_req.wr || mem_req.rd) begin
                rng = xorshift32(rng);
                lat = 1 + int'(rng[2:0]);       // 1 to 8 cycles.
                repeat (lat - 1) begin
                    @(posedge clk_133MHz_210);
                    #1;
                end
                if (mem_req.wr) begin
                    for (int i = 0; i < BURST_LEN; i++) begin
                        key = 32'(mem_req.addr) + 32'(i);
                        store[key] = mem_req.data[i];
                    end
                    mem_rsp.wr_done = 1'b1;
                end else begin
                    for (int i = 0; i < BURST_LEN; i++) begin
                        key = 32'(mem_req.addr) + 32'(i);
                        if (store.exists(key)) rd_burst[i] = store[key];
                        else rd_burst[i].word = 16'(key >> 8) ^ 16'(key);  // Fill.
                    end
                    if (fault_en && (rd_count == fault_read)) begin
                        rd_burst[fault_word].word = rd_burst[fault_word].word
                                                    ^ (16'h1 << fault_bit);
                    end
                    rd_count        = rd_count + 8'd1;
                    mem_rsp.data    = rd_burst;
                    mem_rsp.rd_done = 1'b1;
                end
                @(posedge clk_133MHz_210);      // Done is one cycle wide.
                #1;
                mem_rsp.wr_done = 1'b0;
                mem_rsp.rd_done = 1'b0;         // Request has dropped by now.
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_sdram_self_test.sv
`default_nettype none

module tb_sdram_self_test import sst_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BAUD_DIV     = 8;
    localparam int PAUSE_CYCLES = 20;
    localparam int FRAME_WORDS  = 16;
    localparam int PASSES       = FRAME_WORDS / BURST_LEN;
    localparam int WAIT_LIMIT   = 2000;     // Cycles per wait loop.
    localparam int QUIET_CYCLES = 3000;     // Idle window after a halt.

    logic              clk_133MHz_210;
    logic              rst_n;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    logic              uart_txd;
    logic              led;
    logic              fault_en;
    logic [7:0]        fault_read;
    logic [WIDX_W-1:0] fault_word;
    logic [3:0]        fault_bit;

    sdram_self_test #(
        .BAUD_DIV     (BAUD_DIV),
        .PAUSE_CYCLES (PAUSE_CYCLES),
        .FRAME_WORDS  (FRAME_WORDS)
    ) i_dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .uart_txd       (uart_txd),
        .led            (led)
    );

    tb_burst_memory i_memory (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .mem_req        (mem_req),
        .mem_rsp        (mem_rsp),
        .fault_en       (fault_en),
        .fault_read     (fault_read),
        .fault_word     (fault_word),
        .fault_bit      (fault_bit)
    );

    initial begin
        clk_133MHz_210 = 1'b0;
        forever #5 clk_133MHz_210 = ~clk_133MHz_210;    // 100 MHz sim clock.
    end

    //////////////////////////////
    // Checks.
    //////////////////////////////
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns: %s = %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_word(input mem_word_u got, input mem_word_u exp, input string name);
        if (got.word !== exp.word) begin
            fail_run($sformatf("[ERROR] %0d ns: %s = %h, expected %h",
                               $time, name, got.word, exp.word));
        end
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Pass n uses address 4n and data n in every word.
    function automatic mem_req_t expected_req(input logic is_wr, input int pass_n);
        mem_req_t req;
        req.wr   = is_wr;
        req.rd   = !is_wr;
        req.addr = ADDR_W'(pass_n * BURST_LEN);
        for (int i = 0; i < BURST_LEN; i++) begin
            req.data[i].word = WORD_W'(pass_n);
        end
        return req;
    endfunction

    task automatic check_idle(input logic exp_led);
        check_bit(uart_txd, 1'b1, "uart_txd");
        check_bit(led, exp_led, "led");
        check_bit(mem_req.wr, 1'b0, "mem_req.wr");
        check_bit(mem_req.rd, 1'b0, "mem_req.rd");
    endtask

    // Never both commands at once.
    always @(negedge clk_133MHz_210) begin
        if (rst_n && mem_req.wr && mem_req.rd) begin
            fail_run("The DUT raised write and read requests together.");
        end
    end

    //////////////////////////////
    // Bounded waits.
    //////////////////////////////
    task automatic wait_request(output mem_req_t got);
        int cnt;
        cnt = 0;
        @(negedge clk_133MHz_210);
        while (!(mem_req.wr || mem_req.rd)) begin
            if (cnt == WAIT_LIMIT) fail_run("Timeout: the DUT raised no memory request.");
            check_bit(uart_txd, 1'b1, "uart_txd");     // No frame between passes.
            cnt++;
            @(negedge clk_133MHz_210);
        end
        got = mem_req;
    endtask

    task automatic wait_request_drop();
        int cnt;
        cnt = 0;
        while (mem_req.wr || mem_req.rd) begin
            if (cnt == WAIT_LIMIT) fail_run("Timeout: the DUT held its memory request.");
            cnt++;
            @(negedge clk_133MHz_210);
        end
    endtask

    task automatic wait_led();
        int cnt;
        cnt = 0;
        while (led !== 1'b1) begin
            if (cnt == WAIT_LIMIT) fail_run("Timeout: the error LED never came on.");
            cnt++;
            @(negedge clk_133MHz_210);
        end
    endtask

    // UART receiver sampling near mid-bit.
    task automatic receive_byte(output logic [7:0] data);
        int cnt;
        cnt = 0;
        @(negedge clk_133MHz_210);
        while (uart_txd !== 1'b0) begin
            if (cnt == WAIT_LIMIT) fail_run("Timeout: no UART start bit arrived.");
            cnt++;
            @(negedge clk_133MHz_210);
        end
        repeat (BAUD_DIV / 2 - 1) @(negedge clk_133MHz_210);
        if (uart_txd !== 1'b0) fail_run("UART start bit did not last to mid-bit.");
        for (int i = 0; i < 8; i++) begin
            repeat (BAUD_DIV) @(negedge clk_133MHz_210);
            data[i] = uart_txd;                         // LSB first.
        end
        repeat (2) begin
            repeat (BAUD_DIV) @(negedge clk_133MHz_210);
            if (uart_txd !== 1'b1) fail_run("UART stop bit was not high.");
        end
    endtask

    //////////////////////////////
    // Sequences.
    //////////////////////////////
    task automatic apply_reset();
        @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b0;
        repeat (3) begin
            @(negedge clk_133MHz_210);
            check_idle(1'b0);
        end
        @(posedge clk_133MHz_210);
        #1;
        rst_n = 1'b1;
        @(negedge clk_133MHz_210);
        check_idle(1'b0);                               // First cycle out of reset.
    endtask

    task automatic run_pass(input int pass_n, input int words);
        mem_req_t   got;
        logic [7:0] hi;
        logic [7:0] lo;
        mem_word_u  seen;
        mem_word_u  exp_word;
        exp_word.word = WORD_W'(pass_n);
        wait_request(got);
        check_req(got, expected_req(1'b1, pass_n), "mem_req");
        check_bit(led, 1'b0, "led");
        wait_request_drop();
        wait_request(got);
        check_req(got, expected_req(1'b0, pass_n), "mem_req");
        for (int k = 0; k < words; k++) begin
            receive_byte(hi);
            check_byte(hi, 8'(pass_n >> 8), $sformatf("uart byte %0d", 2 * k));
            receive_byte(lo);
            seen.bytes.hi = hi;
            seen.bytes.lo = lo;
            check_word(seen, exp_word, $sformatf("uart word %0d", k));
        end
    endtask

    task automatic quiet_window(input logic exp_led);
        repeat (QUIET_CYCLES) begin
            @(negedge clk_133MHz_210);
            check_idle(exp_led);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        fault_en   = 1'b0;
        fault_read = 8'd0;
        fault_word = '0;
        fault_bit  = 4'd0;

        // Clean run over the whole frame buffer.
        apply_reset();
        for (int n = 0; n < PASSES; n++) begin
            run_pass(n, BURST_LEN);
        end
        quiet_window(1'b0);                             // Halted with the LED off.

        // Bit 5 of word 2 flipped on the second read.
        @(posedge clk_133MHz_210);
        #1;
        fault_en   = 1'b1;
        fault_read = 8'd1;
        fault_word = WIDX_W'(2);
        fault_bit  = 4'd5;
        apply_reset();
        run_pass(0, BURST_LEN);
        run_pass(1, 2);                                 // Words 0 and 1 only.
        wait_led();
        quiet_window(1'b1);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
sst_pkg.sv
step_timer.sv
pattern_checker.sv
uart_frame_shifter.sv
test_sequencer.sv
sdram_self_test.sv
tb_burst_memory.sv
tb_sdram_self_test.sv

//--- run_sim.sh
#!/bin/sh
# Build the SDRAM self-test simulation with Verilator, run it, look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_sdram_self_test \
    -f sources.f -o sim_tb || { echo "Build failed"; exit 1; }
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
